// ==== logic/mem_pkg.sv ====
package mem_pkg;

    // Fill queue sizing and modeled memory delay
    localparam int FLQ_NUM_ENTRIES = 4;
    localparam int FILL_LATENCY    = 8;

    // Address split is tag | index | offset
    localparam int PADDR_BITS  = 16;
    localparam int INDEX_BITS  = 4;
    localparam int OFFSET_BITS = 4;
    localparam int TAG_BITS    = 8;

    typedef logic [PADDR_BITS-1:0]              t_paddr;
    typedef logic [3:0]                         t_req_id;
    typedef logic [$clog2(FLQ_NUM_ENTRIES)-1:0] t_flq_id;
    typedef logic [TAG_BITS-1:0]                t_tag;
    typedef logic [INDEX_BITS-1:0]              t_index;

    typedef enum logic {
        ARB_LOAD,
        ARB_FILL
    } t_arb_type;

    // Decision taken at mm5
    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_HIT,
        ACT_MISS_ALLOC,
        ACT_MISS_FULL,
        ACT_FILL
    } t_mempipe_action;

    typedef enum logic [1:0] {
        RESP_HIT,
        RESP_FILLED,
        RESP_RETRY
    } t_resp_status;

    // Packet travelling down the pipe
    typedef struct packed {
        t_arb_type arb_type;
        t_paddr    addr;
        t_req_id   id;
        t_flq_id   flq_id;
    } t_mempipe_arb;

    // Captured by a fill queue entry on allocation
    typedef struct packed {
        t_paddr  paddr;
        t_req_id alloc_id;
    } t_flq_static;

endpackage

// ==== logic/flq_entry_if.sv ====
interface flq_entry_if;
    import mem_pkg::*;

    logic         alloc;
    t_flq_static  alloc_static;
    logic         busy;
    // req holds with a stable req_pkt until gnt
    logic         req;
    t_mempipe_arb req_pkt;
    logic         gnt;

    modport queue (
        output alloc, alloc_static, gnt,
        input  busy, req, req_pkt
    );

    modport entry (
        input  alloc, alloc_static, gnt,
        output busy, req, req_pkt
    );

endinterface

// ==== logic/gen_arbiter.sv ====
module gen_arbiter (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic [mem_pkg::FLQ_NUM_ENTRIES-1:0]      int_req_valids,
    input  mem_pkg::t_mempipe_arb                    int_req_pkts [mem_pkg::FLQ_NUM_ENTRIES],
    output logic [mem_pkg::FLQ_NUM_ENTRIES-1:0]      int_gnts,
    output logic                                     ext_req_valid,
    output mem_pkg::t_mempipe_arb                    ext_req_pkt,
    input  logic                                     ext_gnt
);
    import mem_pkg::*;

    t_flq_id ff_idx;

    // Lowest numbered requester wins
    always_comb begin
        ff_idx = '0;
        for (int i = FLQ_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (int_req_valids[i]) begin
                ff_idx = t_flq_id'(i);
            end
        end
    end

    assign ext_req_valid = int_req_valids[ff_idx];
    assign ext_req_pkt   = int_req_pkts[ff_idx];

    // Grant goes back to the winner only
    always_comb begin
        int_gnts         = '0;
        int_gnts[ff_idx] = ext_gnt && ext_req_valid;
    end

endmodule

// ==== logic/fillq_entry.sv ====
module fillq_entry (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_pkg::t_flq_id      id,
    flq_entry_if.entry            ent,
    input  logic                  pipe_valid_mm5,
    input  mem_pkg::t_mempipe_arb pipe_req_pkt_mm5
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MEM,
        REQ_PIPE,
        IN_PIPE
    } t_flq_state;

    typedef logic [$clog2(FILL_LATENCY+1)-1:0] t_delay;

    t_flq_state  state;
    t_delay      delay_cnt;
    t_flq_static miss;
    logic        own_fill_mm5;

    // Our FILL packet has reached the tag array
    assign own_fill_mm5 = pipe_valid_mm5
                       && (pipe_req_pkt_mm5.arb_type == ARB_FILL)
                       && (pipe_req_pkt_mm5.flq_id == id);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            delay_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (ent.alloc) begin
                        state     <= WAIT_MEM;
                        delay_cnt <= t_delay'(FILL_LATENCY);
                    end
                end
                WAIT_MEM: begin
                    // Last wait cycle when one count remains
                    delay_cnt <= delay_cnt - 1'b1;
                    if (delay_cnt == t_delay'(1)) begin
                        state <= REQ_PIPE;
                    end
                end
                REQ_PIPE: begin
                    if (ent.gnt) begin
                        state <= IN_PIPE;
                    end
                end
                IN_PIPE: begin
                    if (own_fill_mm5) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Miss details latched at allocation
    always_ff @(posedge clk) begin
        if (state == IDLE && ent.alloc) begin
            miss <= ent.alloc_static;
        end
    end

    assign ent.busy = (state != IDLE);
    assign ent.req  = (state == REQ_PIPE);

    always_comb begin
        ent.req_pkt.arb_type = ARB_FILL;
        ent.req_pkt.addr     = miss.paddr;
        ent.req_pkt.id       = miss.alloc_id;
        ent.req_pkt.flq_id   = id;
    end

endmodule

// ==== logic/fillq.sv ====
module fillq (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flq_alloc_mm5,
    input  mem_pkg::t_mempipe_arb pipe_req_pkt_mm5,
    input  logic                  pipe_valid_mm5,
    output logic                  pipe_req,
    output mem_pkg::t_mempipe_arb pipe_req_pkt,
    input  logic                  pipe_gnt,
    output logic                  flq_full
);
    import mem_pkg::*;

    logic [FLQ_NUM_ENTRIES-1:0] e_busy;
    logic [FLQ_NUM_ENTRIES-1:0] e_alloc;
    logic [FLQ_NUM_ENTRIES-1:0] e_req;
    logic [FLQ_NUM_ENTRIES-1:0] e_gnt;
    t_mempipe_arb               e_req_pkt [FLQ_NUM_ENTRIES];
    t_flq_static                alloc_static_mm5;

    flq_entry_if ent_if [FLQ_NUM_ENTRIES] ();

    // First free entry takes the miss
    always_comb begin
        logic found;
        found   = 1'b0;
        e_alloc = '0;
        for (int e = 0; e < FLQ_NUM_ENTRIES; e++) begin
            if (flq_alloc_mm5 && !e_busy[e] && !found) begin
                e_alloc[e] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    always_comb begin
        alloc_static_mm5.paddr    = pipe_req_pkt_mm5.addr;
        alloc_static_mm5.alloc_id = pipe_req_pkt_mm5.id;
    end

    assign flq_full = &e_busy;

    gen_arbiter pipe_arb (
        .clk,
        .reset,
        .int_req_valids ( e_req        ),
        .int_req_pkts   ( e_req_pkt    ),
        .int_gnts       ( e_gnt        ),
        .ext_req_valid  ( pipe_req     ),
        .ext_req_pkt    ( pipe_req_pkt ),
        .ext_gnt        ( pipe_gnt     )
    );

    for (genvar e = 0; e < FLQ_NUM_ENTRIES; e++) begin : g_entries
        assign ent_if[e].alloc        = e_alloc[e];
        assign ent_if[e].alloc_static = alloc_static_mm5;
        assign ent_if[e].gnt          = e_gnt[e];
        assign e_busy[e]              = ent_if[e].busy;
        assign e_req[e]               = ent_if[e].req;
        assign e_req_pkt[e]           = ent_if[e].req_pkt;

        fillq_entry entry (
            .clk,
            .reset,
            .id               ( t_flq_id'(e) ),
            .ent              ( ent_if[e]    ),
            .pipe_valid_mm5,
            .pipe_req_pkt_mm5
        );
    end

endmodule

// ==== logic/mem_tags.sv ====
module mem_tags (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pipe_valid_mm5,
    input  mem_pkg::t_mempipe_arb    pipe_req_pkt_mm5,
    input  logic                     flq_full,
    output mem_pkg::t_mempipe_action pipe_action_mm5,
    output logic                     flq_alloc_mm5
);
    import mem_pkg::*;

    logic [2**INDEX_BITS-1:0] tag_valid;
    t_tag                     tag_array [2**INDEX_BITS];

    t_index index_mm5;
    t_tag   tag_mm5;
    logic   hit_mm5;

    // Offset bits are ignored, one tag per line
    assign index_mm5 = pipe_req_pkt_mm5.addr[OFFSET_BITS +: INDEX_BITS];
    assign tag_mm5   = pipe_req_pkt_mm5.addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    assign hit_mm5   = tag_valid[index_mm5] && (tag_array[index_mm5] == tag_mm5);

    always_comb begin
        pipe_action_mm5 = ACT_NONE;
        if (pipe_valid_mm5) begin
            if (pipe_req_pkt_mm5.arb_type == ARB_FILL) begin
                pipe_action_mm5 = ACT_FILL;
            end else if (hit_mm5) begin
                pipe_action_mm5 = ACT_HIT;
            end else if (flq_full) begin
                // No entry left, requester must try again
                pipe_action_mm5 = ACT_MISS_FULL;
            end else begin
                pipe_action_mm5 = ACT_MISS_ALLOC;
            end
        end
    end

    assign flq_alloc_mm5 = (pipe_action_mm5 == ACT_MISS_ALLOC);

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_valid <= '0;
        end else if (pipe_action_mm5 == ACT_FILL) begin
            tag_valid[index_mm5] <= 1'b1;
        end
    end

    // Fill replaces whatever line the set held
    always_ff @(posedge clk) begin
        if (pipe_action_mm5 == ACT_FILL) begin
            tag_array[index_mm5] <= tag_mm5;
        end
    end

endmodule

// ==== logic/mempipe.sv ====
module mempipe (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  mem_pkg::t_paddr       req_addr,
    input  mem_pkg::t_req_id      req_id,
    output logic                  resp_valid,
    output mem_pkg::t_req_id      resp_id,
    output mem_pkg::t_resp_status resp_status
);
    import mem_pkg::*;

    logic            pipe_req;
    t_mempipe_arb    pipe_req_pkt;
    logic            pipe_gnt;
    logic            flq_full;
    logic            flq_alloc_mm5;
    t_mempipe_action pipe_action_mm5;

    logic            pipe_valid_mm0;
    t_mempipe_arb    pipe_req_pkt_mm0;
    logic [5:1]      stage_valid;
    t_mempipe_arb    stage_pkt [1:5];
    logic            pipe_valid_mm5;
    t_mempipe_arb    pipe_req_pkt_mm5;

    // mm0 arbitration, fills always win
    assign pipe_gnt       = pipe_req;
    assign req_ready      = !pipe_req;
    assign pipe_valid_mm0 = pipe_req || req_valid;

    always_comb begin
        if (pipe_req) begin
            pipe_req_pkt_mm0 = pipe_req_pkt;
        end else begin
            pipe_req_pkt_mm0.arb_type = ARB_LOAD;
            pipe_req_pkt_mm0.addr     = req_addr;
            pipe_req_pkt_mm0.id       = req_id;
            pipe_req_pkt_mm0.flq_id   = '0;
        end
    end

    // mm1 to mm5, no stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[4:1], pipe_valid_mm0};
        end
    end

    always_ff @(posedge clk) begin
        stage_pkt[1] <= pipe_req_pkt_mm0;
        for (int s = 2; s <= 5; s++) begin
            stage_pkt[s] <= stage_pkt[s-1];
        end
    end

    assign pipe_valid_mm5   = stage_valid[5];
    assign pipe_req_pkt_mm5 = stage_pkt[5];

    mem_tags tags (
        .clk,
        .reset,
        .pipe_valid_mm5,
        .pipe_req_pkt_mm5,
        .flq_full,
        .pipe_action_mm5,
        .flq_alloc_mm5
    );

    fillq flq (
        .clk,
        .reset,
        .flq_alloc_mm5,
        .pipe_req_pkt_mm5,
        .pipe_valid_mm5,
        .pipe_req,
        .pipe_req_pkt,
        .pipe_gnt,
        .flq_full
    );

    // Response straight off mm5, an allocating miss stays silent
    always_comb begin
        resp_valid  = 1'b0;
        resp_status = RESP_HIT;
        case (pipe_action_mm5)
            ACT_HIT: begin
                resp_valid  = 1'b1;
                resp_status = RESP_HIT;
            end
            ACT_FILL: begin
                resp_valid  = 1'b1;
                resp_status = RESP_FILLED;
            end
            ACT_MISS_FULL: begin
                resp_valid  = 1'b1;
                resp_status = RESP_RETRY;
            end
            default: begin
                resp_valid = 1'b0;
            end
        endcase
    end

    assign resp_id = pipe_req_pkt_mm5.id;

endmodule

// ==== sim/mempipe_tb.sv ====
module mempipe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    typedef struct {
        t_paddr       addr;
        t_req_id      id;
        bit           drain;
        bit           fixed;
        t_resp_status exp;
    } t_row;

    // One accepted load in flight or waiting for its fill
    typedef struct {
        t_paddr       addr;
        t_req_id      id;
        int           mm0_cyc;
        int           alloc_cyc;
        bit           fixed;
        t_resp_status exp;
    } t_load;

    logic         clk;
    logic         reset;
    logic         req_valid;
    logic         req_ready;
    t_paddr       req_addr;
    t_req_id      req_id;
    logic         resp_valid;
    t_req_id      resp_id;
    t_resp_status resp_status;

    t_row   rows[$];
    t_load  inflight[$];
    t_load  pending[$];
    int     row_idx;
    int     cyc;
    int     checks;
    int     errors;
    int     accepted;
    int     finals;
    bit     table_ready;
    integer seed;

    // Reference tag store with 16 sets
    bit   model_valid [16];
    t_tag model_tag [16];

    mempipe mempipe_i (
        .clk,
        .reset,
        .req_valid,
        .req_ready,
        .req_addr,
        .req_id,
        .resp_valid,
        .resp_id,
        .resp_status
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic expect_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("[FAIL] %0t: %s", $time, msg);
        end
    endtask

    task automatic add_row(input t_paddr addr, input t_req_id id, input bit drain,
                           input bit fixed, input t_resp_status exp);
        t_row row;
        row.addr  = addr;
        row.id    = id;
        row.drain = drain;
        row.fixed = fixed;
        row.exp   = exp;
        rows.push_back(row);
    endtask

    function automatic t_index index_of(input t_paddr addr);
        return addr[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic t_tag tag_of(input t_paddr addr);
        return addr[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    endfunction

    task automatic build_table();
        integer r;
        t_tag   rtag;
        t_index ridx;
        // Cold miss then hits on the same line
        add_row(16'h1230, 4'd1, 1'b1, 1'b1, RESP_FILLED);
        add_row(16'h1230, 4'd2, 1'b1, 1'b1, RESP_HIT);
        add_row(16'h123c, 4'd3, 1'b1, 1'b1, RESP_HIT);
        // Six misses back to back against a four entry queue
        add_row(16'h2000, 4'd4, 1'b0, 1'b1, RESP_FILLED);
        add_row(16'h2010, 4'd5, 1'b0, 1'b1, RESP_FILLED);
        add_row(16'h2020, 4'd6, 1'b0, 1'b1, RESP_FILLED);
        add_row(16'h2030, 4'd7, 1'b0, 1'b1, RESP_FILLED);
        add_row(16'h2040, 4'd8, 1'b0, 1'b1, RESP_RETRY);
        add_row(16'h2050, 4'd9, 1'b1, 1'b1, RESP_RETRY);
        // Same set with a different tag evicts
        add_row(16'h4560, 4'd10, 1'b1, 1'b1, RESP_FILLED);
        add_row(16'h7760, 4'd11, 1'b1, 1'b1, RESP_FILLED);
        add_row(16'h4568, 4'd12, 1'b1, 1'b1, RESP_FILLED);
        // Misses followed by a stream of hits that runs into the returning fills
        add_row(16'h5000, 4'd13, 1'b0, 1'b1, RESP_FILLED);
        add_row(16'h5010, 4'd14, 1'b0, 1'b1, RESP_FILLED);
        add_row(16'h5040, 4'd15, 1'b0, 1'b1, RESP_FILLED);
        for (int k = 0; k < 16; k++) begin
            case (k % 3)
                0: add_row(16'h2024, t_req_id'(k % 12), k == 15, 1'b1, RESP_HIT);
                1: add_row(16'h2038, t_req_id'(k % 12), k == 15, 1'b1, RESP_HIT);
                default: add_row(16'h456c, t_req_id'(k % 12), k == 15, 1'b1, RESP_HIT);
            endcase
        end
        // Random lines over four tags and two sets
        for (int k = 0; k < 16; k++) begin
            r    = $random(seed);
            rtag = 8'h31 + {6'd0, r[1:0]};
            ridx = r[2] ? 4'ha : 4'hb;
            add_row({rtag, ridx, r[7:4]}, t_req_id'(k), 1'b1, 1'b0, RESP_HIT);
        end
    endtask

    task automatic wait_drain();
        while (inflight.size() != 0 || pending.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Reference model and response checks at the falling edge
    always @(negedge clk) begin
        t_load        rec;
        t_resp_status want;
        int           idx;
        if (!reset) begin
            if (inflight.size() != 0 && inflight[0].mm0_cyc + 5 == cyc) begin
                rec = inflight.pop_front();
                if (model_valid[index_of(rec.addr)] && model_tag[index_of(rec.addr)]
                        == tag_of(rec.addr)) begin
                    want = RESP_HIT;
                end else if (pending.size() >= FLQ_NUM_ENTRIES) begin
                    want = RESP_RETRY;
                end else begin
                    want = RESP_FILLED;
                end
                if (want == RESP_FILLED) begin
                    expect_true(!resp_valid, $sformatf(
                        "id %0d addr %h should allocate silently, got a response", rec.id,
                        rec.addr));
                    rec.alloc_cyc = cyc;
                    pending.push_back(rec);
                end else begin
                    expect_true(resp_valid && resp_id == rec.id && resp_status == want,
                        $sformatf("id %0d addr %h expects status %0d, got v=%0b id=%0d s=%0d",
                        rec.id, rec.addr, want, resp_valid, resp_id, resp_status));
                    finals++;
                end
                if (rec.fixed) begin
                    expect_true(rec.exp == want, $sformatf(
                        "id %0d addr %h table expects status %0d, model gives %0d", rec.id,
                        rec.addr, rec.exp, want));
                end
            end else if (resp_valid) begin
                idx = -1;
                foreach (pending[i]) begin
                    if (idx < 0 && pending[i].id == resp_id) begin
                        idx = i;
                    end
                end
                checks++;
                assert (idx >= 0) else begin
                    errors++;
                    $display("Response for id %0d arrived with no request waiting for it",
                             resp_id);
                end
                if (idx >= 0) begin
                    rec = pending[idx];
                    pending.delete(idx);
                    expect_true(resp_status == RESP_FILLED, $sformatf(
                        "id %0d expects FILLED, got status %0d", rec.id, resp_status));
                    expect_true(cyc - rec.alloc_cyc >= FILL_LATENCY + 6, $sformatf(
                        "id %0d filled after %0d cycles", rec.id, cyc - rec.alloc_cyc));
                    model_valid[index_of(rec.addr)] = 1'b1;
                    model_tag[index_of(rec.addr)]   = tag_of(rec.addr);
                    finals++;
                end
            end
            if (req_valid && req_ready) begin
                rec.addr    = req_addr;
                rec.id      = req_id;
                rec.mm0_cyc = cyc;
                rec.fixed   = rows[row_idx].fixed;
                rec.exp     = rows[row_idx].exp;
                inflight.push_back(rec);
                accepted++;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * (FILL_LATENCY + 40)) @(posedge clk);
        $display("Timeout: the run did not finish in %0d cycles",
                 rows.size() * (FILL_LATENCY + 40));
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk         = 1'b0;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_addr    = '0;
        req_id      = '0;
        cyc         = 0;
        checks      = 0;
        errors      = 0;
        accepted    = 0;
        finals      = 0;
        row_idx     = 0;
        seed        = 62;
        table_ready = 1'b0;
        for (int s = 0; s < 16; s++) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
        end
        build_table();
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        expect_true(!resp_valid && req_ready && !mempipe_i.flq_full,
                    "outputs not at their reset values");
        @(posedge clk);
        #2;

        for (int r = 0; r < rows.size(); r++) begin
            row_idx   = r;
            req_valid = 1'b1;
            req_addr  = rows[r].addr;
            req_id    = rows[r].id;
            // Hold the request while fills own the pipe
            do begin
                @(negedge clk);
            end while (!req_ready);
            @(posedge clk);
            #2;
            req_valid = 1'b0;
            if (rows[r].drain) begin
                wait_drain();
            end
        end

        wait_drain();
        repeat (FILL_LATENCY + 10) @(posedge clk);
        expect_true(accepted == rows.size(), $sformatf(
            "%0d requests accepted for %0d rows", accepted, rows.size()));
        expect_true(finals == accepted, $sformatf(
            "%0d final responses for %0d accepted requests", finals, accepted));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== mempipe.f ====
logic/mem_pkg.sv
logic/flq_entry_if.sv
logic/gen_arbiter.sv
logic/fillq_entry.sv
logic/fillq.sv
logic/mem_tags.sv
logic/mempipe.sv
sim/mempipe_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module mempipe_tb -f mempipe.f -Mdir obj_dir

run: compile
	./obj_dir/Vmempipe_tb | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
